/* common/histCtrlPkg.sv */
`default_nettype none

// channel sequencing and pixel selection
package histCtrlPkg;

    typedef enum logic [2:0] {
        IDLE,    // waiting for start
        CLEAR,   // zero sweep over all bins
        ACQUIRE, // counting photons
        DRAIN,   // last writes land
        SCAN,    // peak search
        REPORT   // result held
    } chanState_t;

    // cycles spent in DRAIN after frame end
    localparam int DRAIN_CYCLES = 2;

    // pixel codes, CH_A wins a tie in the merge
    localparam logic CH_A = 1'b0;
    localparam logic CH_B = 1'b1;

endpackage

`default_nettype wire

/* common/histGeomPkg.sv */
`default_nettype none

// histogram geometry, shared by every block of the design
package histGeomPkg;

    // photon time code as delivered by the pixel TDC
    localparam int TIME_W = 10;

    // bin address, taken from the top of the time code
    localparam int BIN_W = 6;
    localparam int NUM_BINS = 1 << BIN_W;

    // per-bin counter
    localparam int COUNT_W = 8;
    localparam logic [COUNT_W-1:0] COUNT_MAX = '1; // counts stick here

    // phase counter inside a channel, one bit wider than a bin address
    localparam int SCAN_CNT_W = BIN_W + 1; // so it can reach NUM_BINS

endpackage

`default_nettype wire

/* dv/sifhTb.sv */
`default_nettype none

module sifhTb;
    import histGeomPkg::*;
    import histCtrlPkg::*;

    localparam int SAT_COUNT = (1 << COUNT_W) - 1;
    localparam int RAND_FRAMES = 3;
    localparam int RAND_PHOTONS = 300;
    localparam int MAX_GAP = 3;
    localparam int NUM_FRAMES = 9;
    localparam int FRAME_OVERHEAD = 2 * NUM_BINS + 64; // clear, drain, scan, merge, strays
    localparam int DIRECTED_CYCLES = 1200;
    localparam int CYCLE_LIMIT = NUM_FRAMES * FRAME_OVERHEAD
        + RAND_FRAMES * RAND_PHOTONS * (MAX_GAP + 1) + DIRECTED_CYCLES + 500;

    logic clk;
    logic res;
    logic start;
    logic frameEnd;
    logic photonValidA;
    logic photonValidB;
    logic [TIME_W-1:0] timeA;
    logic [TIME_W-1:0] timeB;
    logic busy;
    logic acquiring;
    logic [BIN_W-1:0] peakBinA;
    logic [BIN_W-1:0] peakBinB;
    logic [COUNT_W-1:0] peakCountA;
    logic [COUNT_W-1:0] peakCountB;
    logic resultValid;
    logic winChannel;
    logic [BIN_W-1:0] winBin;
    logic [COUNT_W-1:0] winCount;

    int modelHist [2][NUM_BINS]; // expected histograms, A then B
    int errors = 0;
    int checks = 0;
    int testErrors = 0;
    int testChecks = 0;
    int testNum = 0;
    int resultsSeen = 0;
    int cycles = 0;
    int frameEndAt = 0; // cycle count in the middle of the frameEnd cycle
    bit watchBusy = 0;

    sifhTop uut (
        .clk          (clk),
        .res          (res),
        .start        (start),
        .frameEnd     (frameEnd),
        .photonValidA (photonValidA),
        .photonValidB (photonValidB),
        .timeA        (timeA),
        .timeB        (timeB),
        .busy         (busy),
        .acquiring    (acquiring),
        .peakBinA     (peakBinA),
        .peakBinB     (peakBinB),
        .peakCountA   (peakCountA),
        .peakCountB   (peakCountB),
        .resultValid  (resultValid),
        .winChannel   (winChannel),
        .winBin       (winBin),
        .winCount     (winCount)
    );

    always #4 clk = ~clk;

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        checks++;
        testChecks++;
        if (actual !== expected) begin
            errors++;
            testErrors++;
            $display("error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    // peak of a model histogram as {bin, count}, lowest bin on ties
    function automatic logic [BIN_W+COUNT_W-1:0] peakOf(input int ch);
        int best;
        int bestBin;
        logic [BIN_W-1:0] b;
        logic [COUNT_W-1:0] c;
        best = -1;
        bestBin = 0;
        for (int i = 0; i < NUM_BINS; i++) begin
            if (modelHist[ch][i] > best) begin
                best = modelHist[ch][i];
                bestBin = i;
            end
        end
        b = bestBin;
        c = best;
        return {b, c};
    endfunction

    function automatic logic [TIME_W-1:0] timeFor(input int bin);
        logic [TIME_W-1:0] t;
        t = $urandom; // random fine bits below the bin
        t[TIME_W-1 -: BIN_W] = bin;
        return t;
    endfunction

    // half the photons near a center bin so a clear peak forms
    function automatic logic [TIME_W-1:0] pickTime(input int center);
        logic [TIME_W-1:0] t;
        if ($urandom_range(0, 1) == 1) begin
            t = timeFor(center + $urandom_range(0, 3));
        end else begin
            t = $urandom;
        end
        return t;
    endfunction

    task automatic countPhoton(input int ch, input logic [TIME_W-1:0] t);
        int b;
        b = t[TIME_W-1 -: BIN_W];
        if (modelHist[ch][b] < SAT_COUNT) begin
            modelHist[ch][b]++;
        end
    endtask

    task automatic clearModel;
        for (int c = 0; c < 2; c++) begin
            for (int b = 0; b < NUM_BINS; b++) begin
                modelHist[c][b] = 0;
            end
        end
    endtask

    task automatic driveCycle(input logic vA, input logic [TIME_W-1:0] tA,
                              input logic vB, input logic [TIME_W-1:0] tB);
        @(posedge clk);
        photonValidA <= vA;
        timeA <= tA;
        photonValidB <= vB;
        timeB <= tB;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) driveCycle(1'b0, '0, 1'b0, '0);
    endtask

    task automatic strayPhotons(input int bin, input int n);
        repeat (n) driveCycle(1'b1, timeFor(bin), 1'b1, timeFor(bin));
        idleCycles(1);
    endtask

    // start pulse, optional photons during CLEAR, then wait for acquisition
    task automatic startFrame(input int strayBin, input int strays);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        clearModel();
        watchBusy = 1;
        strayPhotons(strayBin, strays);
        @(negedge clk);
        while (!acquiring) @(negedge clk);
    endtask

    task automatic endFrame;
        @(posedge clk);
        frameEnd <= 1'b1;
        photonValidA <= 1'b0;
        photonValidB <= 1'b0;
        @(negedge clk);
        frameEndAt = cycles;
        @(posedge clk);
        frameEnd <= 1'b0;
    endtask

    task automatic waitResult;
        int seen;
        seen = resultsSeen;
        while (resultsSeen == seen) @(negedge clk);
    endtask

    task automatic finishTest(input string name);
        testNum++;
        $display("test %0d %s: %0d checks, %0d errors", testNum, name, testChecks, testErrors);
        testChecks = 0;
        testErrors = 0;
    endtask

    // model follows only photons the DUT can see
    always @(negedge clk) begin
        if (res && acquiring) begin
            if (photonValidA) countPhoton(0, timeA);
            if (photonValidB) countPhoton(1, timeB);
        end
    end

    always @(negedge clk) begin
        if (res && watchBusy && !resultValid) begin
            compareValue("busy", busy, 1);
        end
    end

    always @(negedge clk) begin : compareResult
        logic [BIN_W+COUNT_W-1:0] refA;
        logic [BIN_W+COUNT_W-1:0] refB;
        logic expWin;
        if (res && resultValid) begin
            refA = peakOf(0);
            refB = peakOf(1);
            // drain, scan, report and merge after the frameEnd cycle
            compareValue("resultValid latency", cycles - frameEndAt, NUM_BINS + 5);
            compareValue("peakBinA", peakBinA, refA[BIN_W+COUNT_W-1 -: BIN_W]);
            compareValue("peakCountA", peakCountA, refA[COUNT_W-1:0]);
            compareValue("peakBinB", peakBinB, refB[BIN_W+COUNT_W-1 -: BIN_W]);
            compareValue("peakCountB", peakCountB, refB[COUNT_W-1:0]);
            expWin = (refB[COUNT_W-1:0] > refA[COUNT_W-1:0]) ? CH_B : CH_A; // A on ties
            compareValue("winChannel", winChannel, expWin);
            compareValue("winBin", winBin, (expWin == CH_B) ?
                refB[BIN_W+COUNT_W-1 -: BIN_W] : refA[BIN_W+COUNT_W-1 -: BIN_W]);
            compareValue("winCount", winCount, (expWin == CH_B) ?
                refB[COUNT_W-1:0] : refA[COUNT_W-1:0]);
            watchBusy = 0;
            resultsSeen++;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: no finish after %0d cycles, a result never arrived", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        int centerA;
        int centerB;
        logic vA;
        logic vB;
        void'($urandom(2011));
        clk = 1'b0;
        res = 1'b0;
        start = 1'b0;
        frameEnd = 1'b0;
        photonValidA = 1'b0;
        photonValidB = 1'b0;
        timeA = '0;
        timeB = '0;
        clearModel();
        repeat (5) @(posedge clk);
        res <= 1'b1;

        // idle outputs after reset, then one small frame
        @(negedge clk);
        compareValue("busy", busy, 0);
        compareValue("acquiring", acquiring, 0);
        compareValue("resultValid", resultValid, 0);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        watchBusy = 1;
        repeat (NUM_BINS) begin
            @(negedge clk);
            compareValue("acquiring", acquiring, 0); // still clearing
        end
        @(negedge clk);
        compareValue("acquiring", acquiring, 1);
        for (int i = 0; i < 12; i++) driveCycle(1'b1, timeFor(i % 5), 1'b1, timeFor(30));
        endFrame();
        waitResult();
        finishTest("reset and status");

        for (int f = 0; f < RAND_FRAMES; f++) begin
            startFrame(0, 0);
            centerA = $urandom_range(0, NUM_BINS - 4);
            centerB = $urandom_range(0, NUM_BINS - 4);
            for (int i = 0; i < RAND_PHOTONS; i++) begin
                idleCycles($urandom_range(0, MAX_GAP));
                vA = $urandom_range(0, 3) != 0;
                vB = $urandom_range(0, 3) != 0;
                driveCycle(vA, pickTime(centerA), vB, pickTime(centerB));
            end
            endFrame();
            waitResult();
        end
        finishTest("random frames");

        // same-bin bursts against alternating bins
        startFrame(0, 0);
        for (int r = 0; r < 3; r++) begin
            for (int i = 0; i < 6; i++) driveCycle(1'b1, timeFor(12), 1'b1, timeFor(40 + i % 2));
            for (int i = 0; i < 10; i++) driveCycle(1'b1, timeFor(12 + i % 2), 1'b1, timeFor(41));
            for (int i = 0; i < 5; i++) begin
                driveCycle(1'b1, timeFor(13), 1'b1, timeFor((i % 3 == 0) ? 40 : 41));
            end
            idleCycles(1);
        end
        endFrame();
        waitResult();
        finishTest("forwarding bursts");

        startFrame(0, 0);
        for (int i = 0; i < SAT_COUNT + 45; i++) begin
            driveCycle(1'b1, timeFor(50), (i % 7) != 3, timeFor(7));
        end
        endFrame();
        waitResult();
        finishTest("saturation");

        // heavy bin 5 in frame one must vanish in frame two
        startFrame(0, 0);
        for (int i = 0; i < 40; i++) driveCycle(1'b1, timeFor(5), 1'b1, timeFor(6));
        endFrame();
        waitResult();
        startFrame(5, 20);
        for (int i = 0; i < 5; i++) driveCycle(1'b1, timeFor(40 + i / 3), i < 2, timeFor(30));
        endFrame();
        strayPhotons(5, 20); // lands in DRAIN and SCAN
        waitResult();
        finishTest("clear and dropped photons");

        startFrame(0, 0);
        for (int i = 0; i < 8; i++) begin
            driveCycle(1'b1, timeFor((i % 2 == 0) ? 20 : 9), i % 2 == 0, timeFor(3));
        end
        endFrame();
        waitResult();
        finishTest("ties");

        $display("tests: %0d, checks: %0d, errors: %0d", testNum, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
common/histGeomPkg.sv
common/histCtrlPkg.sv
hw/histRam.sv
histChannel/histChannel.sv
hw/peakMerge.sv
hw/sifhTop.sv
dv/sifhTb.sv

/* histChannel/histChannel.sv */
`default_nettype none

// one pixel: clear sweep, photon counting, peak scan
module histChannel (
    input  logic                            clk,
    input  logic                            res,
    input  logic                            start,
    input  logic                            frameEnd,
    input  logic                            photonValid,
    input  logic [histGeomPkg::TIME_W-1:0]  photonTime,
    output logic                            acquiring,
    output logic                            busy,
    output logic                            peakValid,
    output logic [histGeomPkg::BIN_W-1:0]   peakBin,
    output logic [histGeomPkg::COUNT_W-1:0] peakCount
);
    import histGeomPkg::*;
    import histCtrlPkg::*;

    chanState_t state;
    chanState_t nextState;
    logic [SCAN_CNT_W-1:0] cnt; // position inside CLEAR, DRAIN or SCAN
    logic cntDone;
    logic startOk;

    // memory side
    logic readEn;
    logic [BIN_W-1:0] readAddr;
    logic writeEn;
    logic [BIN_W-1:0] writeAddr;
    logic [COUNT_W-1:0] writeData;
    logic [COUNT_W-1:0] readData;

    // increment pipeline
    logic [BIN_W-1:0] photonBin;
    logic photonTake;
    logic p1Valid; // photon whose read was issued last cycle
    logic [BIN_W-1:0] p1Bin;
    logic wrValidQ; // write issued last cycle
    logic [BIN_W-1:0] wrBinQ;
    logic [COUNT_W-1:0] wrDataQ;
    logic fwdHit;
    logic [COUNT_W-1:0] baseCount;
    logic [COUNT_W-1:0] incCount;

    // peak search
    logic scanRdValid;
    logic [BIN_W-1:0] scanRdBin;
    logic [COUNT_W-1:0] runMax;
    logic [BIN_W-1:0] runBin;

    histRam ram (
        .clk       (clk),
        .readEn    (readEn),
        .readAddr  (readAddr),
        .writeEn   (writeEn),
        .writeAddr (writeAddr),
        .writeData (writeData),
        .readData  (readData)
    );

    assign startOk = start && (state == IDLE || state == REPORT);

    always_comb begin
        case (state)
            CLEAR:   cntDone = cnt == SCAN_CNT_W'(NUM_BINS - 1);
            DRAIN:   cntDone = cnt == SCAN_CNT_W'(DRAIN_CYCLES - 1);
            SCAN:    cntDone = cnt == SCAN_CNT_W'(NUM_BINS); // last compare cycle
            default: cntDone = 1'b0;
        endcase
    end

    always_comb begin
        nextState = state;
        case (state)
            IDLE:    if (start) nextState = CLEAR;
            CLEAR:   if (cntDone) nextState = ACQUIRE;
            ACQUIRE: if (frameEnd) nextState = DRAIN;
            DRAIN:   if (cntDone) nextState = SCAN;
            SCAN:    if (cntDone) nextState = REPORT;
            REPORT:  if (start) nextState = CLEAR;
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= IDLE;
            cnt <= '0;
        end else begin
            state <= nextState;
            if (nextState != state) begin
                cnt <= '0; // every phase starts from zero
            end else if (state inside {CLEAR, DRAIN, SCAN}) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // bin = top bits of the time code
    assign photonBin = photonTime[TIME_W-1 -: BIN_W];
    assign photonTake = photonValid && state == ACQUIRE; // others are dropped

    // back-to-back hit: ram still holds the value before last write
    assign fwdHit = wrValidQ && wrBinQ == p1Bin;
    assign baseCount = fwdHit ? wrDataQ : readData;
    assign incCount = (baseCount == COUNT_MAX) ? COUNT_MAX : baseCount + 1'b1;

    always_comb begin
        readEn = 1'b0;
        readAddr = photonBin;
        if (state == ACQUIRE) begin
            readEn = photonTake;
        end else if (state == SCAN) begin
            readEn = !cntDone; // one read per bin
            readAddr = cnt[BIN_W-1:0];
        end
    end

    always_comb begin
        if (state == CLEAR) begin
            writeEn = 1'b1;
            writeAddr = cnt[BIN_W-1:0];
            writeData = '0;
        end else begin
            writeEn = p1Valid; // second half of read-modify-write
            writeAddr = p1Bin;
            writeData = incCount;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            p1Valid <= 1'b0;
            wrValidQ <= 1'b0;
            scanRdValid <= 1'b0;
            peakValid <= 1'b0;
        end else begin
            p1Valid <= photonTake;
            wrValidQ <= p1Valid;
            scanRdValid <= state == SCAN && !cntDone;
            peakValid <= state == SCAN && cntDone; // first cycle of REPORT
        end
    end

    always_ff @(posedge clk) begin
        p1Bin <= photonBin;
        wrBinQ <= p1Bin;
        wrDataQ <= incCount;
        scanRdBin <= cnt[BIN_W-1:0];
    end

    // strict compare keeps the lowest bin on ties
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            runMax <= '0;
            runBin <= '0;
        end else if (startOk) begin
            runMax <= '0;
            runBin <= '0;
        end else if (scanRdValid && readData > runMax) begin
            runMax <= readData;
            runBin <= scanRdBin;
        end
    end

    assign acquiring = state == ACQUIRE;
    assign busy = (state inside {CLEAR, ACQUIRE, DRAIN, SCAN}) || peakValid;
    assign peakBin = runBin;
    assign peakCount = runMax;

    noWriteInIdle: assert property (@(posedge clk) disable iff (!res)
        state == IDLE |-> !writeEn);

    peakPulse: assert property (@(posedge clk) disable iff (!res)
        peakValid |=> !peakValid);

    // running max only grows while scanning
    maxMonotonic: assert property (@(posedge clk) disable iff (!res)
        state == SCAN && $past(state) == SCAN |-> runMax >= $past(runMax));

endmodule

`default_nettype wire

/* hw/histRam.sv */
`default_nettype none

// count memory, one write port and one registered read port
module histRam (
    input  logic                            clk,
    input  logic                            readEn,
    input  logic [histGeomPkg::BIN_W-1:0]   readAddr,
    input  logic                            writeEn,
    input  logic [histGeomPkg::BIN_W-1:0]   writeAddr,
    input  logic [histGeomPkg::COUNT_W-1:0] writeData,
    output logic [histGeomPkg::COUNT_W-1:0] readData
);
    import histGeomPkg::*;

    logic [COUNT_W-1:0] mem [NUM_BINS];

    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[writeAddr] <= writeData;
        end
    end

    // read-before-write on an address collision
    always_ff @(posedge clk) begin
        if (readEn) begin
            readData <= mem[readAddr];
        end
    end

endmodule

`default_nettype wire

/* hw/peakMerge.sv */
`default_nettype none

// combines the two channel peaks into one winner
module peakMerge (
    input  logic                            clk,
    input  logic                            res,
    input  logic                            start,
    input  logic                            peakValidA,
    input  logic                            peakValidB,
    input  logic [histGeomPkg::BIN_W-1:0]   peakBinA,
    input  logic [histGeomPkg::BIN_W-1:0]   peakBinB,
    input  logic [histGeomPkg::COUNT_W-1:0] peakCountA,
    input  logic [histGeomPkg::COUNT_W-1:0] peakCountB,
    output logic                            resultValid,
    output logic                            winChannel,
    output logic [histGeomPkg::BIN_W-1:0]   winBin,
    output logic [histGeomPkg::COUNT_W-1:0] winCount
);
    import histCtrlPkg::*;

    logic pendA;
    logic pendB;
    logic bothReady;

    // later pulse may be the one arriving right now
    assign bothReady = (pendA || peakValidA) && (pendB || peakValidB);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            pendA <= 1'b0;
            pendB <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            if (start || bothReady) begin
                pendA <= 1'b0;
                pendB <= 1'b0;
            end else begin
                pendA <= pendA || peakValidA;
                pendB <= pendB || peakValidB;
            end
            resultValid <= bothReady;
        end
    end

    always_ff @(posedge clk) begin
        if (bothReady) begin
            if (peakCountB > peakCountA) begin
                winChannel <= CH_B;
                winBin <= peakBinB;
                winCount <= peakCountB;
            end else begin
                winChannel <= CH_A; // tie goes to A
                winBin <= peakBinA;
                winCount <= peakCountA;
            end
        end
    end

    winIsMax: assert property (@(posedge clk) disable iff (!res)
        resultValid |-> winCount >= peakCountA && winCount >= peakCountB);

endmodule

`default_nettype wire

/* hw/sifhTop.sv */
`default_nettype none

// two pixel histograms side by side plus the winner merge
module sifhTop (
    input  logic                            clk,
    input  logic                            res,
    input  logic                            start,
    input  logic                            frameEnd,
    input  logic                            photonValidA,
    input  logic                            photonValidB,
    input  logic [histGeomPkg::TIME_W-1:0]  timeA,
    input  logic [histGeomPkg::TIME_W-1:0]  timeB,
    output logic                            busy,
    output logic                            acquiring,
    output logic [histGeomPkg::BIN_W-1:0]   peakBinA,
    output logic [histGeomPkg::BIN_W-1:0]   peakBinB,
    output logic [histGeomPkg::COUNT_W-1:0] peakCountA,
    output logic [histGeomPkg::COUNT_W-1:0] peakCountB,
    output logic                            resultValid,
    output logic                            winChannel,
    output logic [histGeomPkg::BIN_W-1:0]   winBin,
    output logic [histGeomPkg::COUNT_W-1:0] winCount
);

    logic peakValidA;
    logic peakValidB;

    // shared start and frameEnd keep both channels in lockstep
    histChannel chanA (
        .clk         (clk),
        .res         (res),
        .start       (start),
        .frameEnd    (frameEnd),
        .photonValid (photonValidA),
        .photonTime  (timeA),
        .acquiring   (acquiring),
        .busy        (busy),
        .peakValid   (peakValidA),
        .peakBin     (peakBinA),
        .peakCount   (peakCountA)
    );

    histChannel chanB (
        .clk         (clk),
        .res         (res),
        .start       (start),
        .frameEnd    (frameEnd),
        .photonValid (photonValidB),
        .photonTime  (timeB),
        .acquiring   (), // same as chanA
        .busy        (),
        .peakValid   (peakValidB),
        .peakBin     (peakBinB),
        .peakCount   (peakCountB)
    );

    peakMerge merge (
        .clk         (clk),
        .res         (res),
        .start       (start),
        .peakValidA  (peakValidA),
        .peakValidB  (peakValidB),
        .peakBinA    (peakBinA),
        .peakBinB    (peakBinB),
        .peakCountA  (peakCountA),
        .peakCountB  (peakCountB),
        .resultValid (resultValid),
        .winChannel  (winChannel),
        .winBin      (winBin),
        .winCount    (winCount)
    );

endmodule

`default_nettype wire
